// File: all.f
rtl/capture_pkg.sv
rtl/sample_fifo.sv
rtl/downsampler.sv
rtl/capture_ctrl.sv
rtl/word_packer.sv
rtl/byte_unpacker.sv
rtl/capture_top.sv
bench/tb_capture.sv

// File: bench/tb_capture.sv
`timescale 1ns/1ps

module tb_capture;

    localparam int CLK_PERIOD = 4;
    localparam int SEED       = 32'h21cf_4a12;
    localparam int N_TESTS    = 5;
    localparam int MAX_P      = 20;   // largest presample of the runs below
    localparam int MAX_M      = 62;
    localparam int MAX_DS     = 3;
    localparam int TAIL       = 20;   // quiet cycles after the last expected byte

    logic                                 adc_sampleclk = 1'b0;
    logic                                 reset;
    capture_pkg::sample_t                 adc_datain_i;
    logic                                 adc_write_mask_i;
    logic                                 adc_capture_go_i;
    logic                                 arm_i;
    logic [capture_pkg::COUNT_W-1:0]      presample_i;
    logic [capture_pkg::COUNT_W-1:0]      max_samples_i;
    logic [capture_pkg::DOWNSAMPLE_W-1:0] downsample_i;
    logic                                 low_res_i;
    logic                                 low_res_lsb_i;
    logic                                 fifo_read_fifoen_i;
    logic                                 adc_capture_stop_o;
    logic [capture_pkg::COUNT_W-1:0]      samples_o;
    logic                                 fifo_read_fifoempty_o;
    capture_pkg::byte_t                   fifo_read_data_o;

    int                   errors = 0;
    int                   checks = 0;
    int unsigned          seed_val;
    bit                   rand_mask = 1'b0;
    bit                   seen_val [4096];   // ramp values present with the mask high
    logic [7:0]           byte_q [$];
    logic [11:0]          samp_q [$];
    logic                 stop_q = 1'b0;
    logic                 wr_q = 1'b0;
    capture_pkg::sample_t trig_val;
    int                   trig_delay;   // negedges from arm to trigger

    // arm and trigger wait, capture at half mask rate, readout and tail
    function automatic int est_cycles(int p, int m, int ds);
        return 40 + (p + 20 + 2 * m) * (ds + 1) + 2 * m + TAIL;
    endfunction

    always #(CLK_PERIOD / 2) adc_sampleclk = ~adc_sampleclk;

    capture_top i_dut (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .adc_datain_i (adc_datain_i),
        .adc_write_mask_i (adc_write_mask_i), .adc_capture_go_i (adc_capture_go_i),
        .arm_i (arm_i), .presample_i (presample_i), .max_samples_i (max_samples_i),
        .downsample_i (downsample_i), .low_res_i (low_res_i), .low_res_lsb_i (low_res_lsb_i),
        .fifo_read_fifoen_i (fifo_read_fifoen_i), .adc_capture_stop_o (adc_capture_stop_o),
        .samples_o (samples_o), .fifo_read_fifoempty_o (fifo_read_fifoempty_o),
        .fifo_read_data_o (fifo_read_data_o)
    );

    always @(negedge adc_sampleclk) begin
        adc_datain_i <= adc_datain_i + 1'b1;   // free-running ramp
        if (rand_mask)
            adc_write_mask_i <= ($urandom % 2) == 1;
        else
            adc_write_mask_i <= 1'b1;
    end

    // byte collection and stop timing
    always @(posedge adc_sampleclk) begin
        if (reset) begin
            stop_q <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            if (adc_write_mask_i)
                seen_val[adc_datain_i] <= 1'b1;
            if (fifo_read_fifoen_i && !fifo_read_fifoempty_o)
                byte_q.push_back(fifo_read_data_o);
            if (adc_capture_stop_o && !stop_q) begin
                checks = checks + 2;
                assert (wr_q) else begin
                    errors++;
                    $display("stop rose without a sample write in the cycle before");
                end
                assert (samples_o == max_samples_i) else begin
                    errors++;
                    $display("mismatch samples_o got %h expected %h", samples_o, max_samples_i);
                end
            end
            stop_q <= adc_capture_stop_o;
            wr_q   <= i_dut.sample_wr;
        end
    end

    task automatic run_capture(input int p, input int m, input int ds, input bit lres,
                               input bit lsb, input bit rnd);
        int delay;
        int cnt;
        int exp_bytes;
        int i;
        delay = (p + 4) * (ds + 1) + $urandom % 16;
        cnt = (m / 6) * 6;
        exp_bytes = lres ? cnt : cnt * 3 / 2;
        trig_delay = delay;
        @(negedge adc_sampleclk);
        presample_i   = p;
        max_samples_i = m;
        downsample_i  = ds;
        low_res_i     = lres;
        low_res_lsb_i = lsb;
        rand_mask     = rnd;
        for (i = 0; i < 4096; i++)
            seen_val[i] = 1'b0;
        byte_q.delete();
        @(negedge adc_sampleclk);
        arm_i = 1'b1;
        repeat (delay) @(negedge adc_sampleclk);
        adc_capture_go_i = 1'b1;
        @(posedge adc_sampleclk);
        trig_val = adc_datain_i;   // sample present at the trigger edge
        @(negedge adc_sampleclk);
        adc_capture_go_i = 1'b0;
        arm_i            = 1'b0;
        while (!adc_capture_stop_o)
            @(posedge adc_sampleclk);
        while (byte_q.size() < exp_bytes)
            @(posedge adc_sampleclk);
        repeat (TAIL) @(posedge adc_sampleclk);   // any late byte shows up here
        checks++;
        assert (byte_q.size() == exp_bytes) else begin
            errors++;
            $display("mismatch fifo_read_data_o byte count got %h expected %h",
                     byte_q.size(), exp_bytes);
        end
    endtask

    // three bytes carry two samples msb first
    task automatic decode_hires();
        int i;
        samp_q.delete();
        for (i = 0; i + 2 < byte_q.size(); i += 3) begin
            samp_q.push_back({byte_q[i], byte_q[i+1][7:4]});
            samp_q.push_back({byte_q[i+1][3:0], byte_q[i+2]});
        end
    endtask

    task automatic check_exact(input int p, input int m, input bit lres, input bit lsb);
        int k;
        int v;
        int cnt;
        logic [11:0] s;
        logic [7:0]  b;
        cnt = (m / 6) * 6;
        decode_hires();
        for (k = 0; k < cnt; k++) begin
            v = trig_val - p + k;   // presamples sit just before the trigger sample
            s = v[11:0];
            b = lsb ? s[7:0] : s[11:4];
            checks++;
            if (lres && k < byte_q.size()) begin
                assert (byte_q[k] === b) else begin
                    errors++;
                    $display("mismatch fifo_read_data_o byte %0d got %h expected %h",
                             k, byte_q[k], b);
                end
            end else if (!lres && k < samp_q.size()) begin
                assert (samp_q[k] === s) else begin
                    errors++;
                    $display("mismatch fifo_read_data_o sample %0d got %h expected %h",
                             k, samp_q[k], s);
                end
            end
        end
    endtask

    task automatic check_stride(input int p, input int ds);
        int k;
        int v;
        int t0;
        logic [11:0] s;
        decode_hires();
        // writes start two edges after arm is seen and repeat every ds+1 edges
        t0 = int'(trig_val) + (ds + 1 - (trig_delay - 2) % (ds + 1)) % (ds + 1);
        for (k = 0; k < samp_q.size(); k++) begin
            v = t0 + (k - p) * (ds + 1);
            s = v[11:0];   // ramp wraps at 4096
            checks++;
            assert (samp_q[k] === s) else begin
                errors++;
                $display("mismatch fifo_read_data_o sample %0d got %h expected %h",
                         k, samp_q[k], s);
            end
        end
    endtask

    task automatic check_masked();
        int k;
        int d;
        decode_hires();
        for (k = 0; k < samp_q.size(); k++) begin
            checks = checks + 2;
            assert (seen_val[samp_q[k]]) else begin
                errors++;
                $display("sample %h was read but never present with the mask high", samp_q[k]);
            end
            d = (k == 0) ? 1 : (int'(samp_q[k]) - int'(samp_q[k-1]) + 4096) % 4096;
            assert (d >= 1 && d < 2048) else begin
                errors++;
                $display("sample %0d arrived out of order", k);
            end
        end
    endtask

    initial begin
        #(N_TESTS * est_cycles(MAX_P, MAX_M, MAX_DS) * CLK_PERIOD * 4 + 2000);
        $display("timeout, capture or readout never finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed_val           = $urandom(SEED);
        reset              = 1'b1;
        adc_datain_i       = '0;
        adc_write_mask_i   = 1'b1;
        adc_capture_go_i   = 1'b0;
        arm_i              = 1'b0;
        presample_i        = '0;
        max_samples_i      = '0;
        downsample_i       = '0;
        low_res_i          = 1'b0;
        low_res_lsb_i      = 1'b0;
        fifo_read_fifoen_i = 1'b0;
        repeat (4) @(negedge adc_sampleclk);
        checks = checks + 2;
        assert (adc_capture_stop_o === 1'b0) else begin
            errors++;
            $display("mismatch adc_capture_stop_o got %h expected %h", adc_capture_stop_o, 1'b0);
        end
        assert (fifo_read_fifoempty_o === 1'b1) else begin
            errors++;
            $display("mismatch fifo_read_fifoempty_o got %h expected %h",
                     fifo_read_fifoempty_o, 1'b1);
        end
        reset              = 1'b0;
        fifo_read_fifoen_i = 1'b1;   // reader always drains

        run_capture(20, 62, 0, 1'b0, 1'b0, 1'b0);   // high res, exact presamples
        check_exact(20, 62, 1'b0, 1'b0);
        run_capture(10, 48, 0, 1'b1, 1'b0, 1'b0);   // low res, top byte
        check_exact(10, 48, 1'b1, 1'b0);
        run_capture(16, 36, 0, 1'b1, 1'b1, 1'b0);   // low res, low byte
        check_exact(16, 36, 1'b1, 1'b1);
        run_capture(8, 54, MAX_DS, 1'b0, 1'b0, 1'b0);
        check_stride(8, MAX_DS);
        run_capture(12, 60, 0, 1'b0, 1'b0, 1'b1);   // random write mask
        check_masked();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: rtl/byte_unpacker.sv
`timescale 1ns/1ps

module byte_unpacker (
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  capture_pkg::word_t   word_i,
    input  logic                 word_empty_i,
    input  logic                 low_res_i,
    input  logic                 low_res_lsb_i,
    input  logic                 fifo_read_fifoen_i,
    output logic                 word_rd_o,
    output capture_pkg::byte_t   fifo_read_data_o
);

    logic [3:0]           byte_idx;
    logic [3:0]           nib_r;      // low nibble of the first word in a pair
    logic                 byte_en;
    capture_pkg::sample_t cur_sample;

    // no byte consumed while the head word is about to be popped
    assign byte_en = fifo_read_fifoen_i && !word_empty_i && !word_rd_o;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            byte_idx  <= '0;
            word_rd_o <= 1'b0;
        end else begin
            word_rd_o <= 1'b0;
            if (byte_en) begin
                if (low_res_i) begin
                    if (byte_idx >= capture_pkg::SAMPLES_PER_WORD - 1) begin
                        byte_idx  <= '0;
                        word_rd_o <= 1'b1;
                    end else begin
                        byte_idx <= byte_idx + 4'd1;
                    end
                end else begin
                    if (byte_idx >= capture_pkg::HIRES_BYTES - 1)
                        byte_idx <= '0;
                    else
                        byte_idx <= byte_idx + 4'd1;
                    // byte 3 ends the first word, byte 8 the second
                    if (byte_idx == 4'd3 || byte_idx == capture_pkg::HIRES_BYTES - 1)
                        word_rd_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (byte_en && !low_res_i && byte_idx == 4'd3)
            nib_r <= word_i[3:0];
    end

    always_comb begin
        case (byte_idx)
            4'd0:    cur_sample = word_i[2*capture_pkg::SAMPLE_W +: capture_pkg::SAMPLE_W];
            4'd1:    cur_sample = word_i[capture_pkg::SAMPLE_W +: capture_pkg::SAMPLE_W];
            default: cur_sample = word_i[0 +: capture_pkg::SAMPLE_W];
        endcase
    end

    always_comb begin
        if (low_res_i) begin
            fifo_read_data_o = low_res_lsb_i ? cur_sample[7:0]
                                             : cur_sample[capture_pkg::SAMPLE_W-1 -: 8];
        end else begin
            case (byte_idx)
                4'd0:    fifo_read_data_o = word_i[35:28];
                4'd1:    fifo_read_data_o = word_i[27:20];
                4'd2:    fifo_read_data_o = word_i[19:12];
                4'd3:    fifo_read_data_o = word_i[11:4];
                4'd4:    fifo_read_data_o = {nib_r, word_i[35:32]};   // split byte
                4'd5:    fifo_read_data_o = word_i[31:24];
                4'd6:    fifo_read_data_o = word_i[23:16];
                4'd7:    fifo_read_data_o = word_i[15:8];
                default: fifo_read_data_o = word_i[7:0];
            endcase
        end
    end

endmodule

// File: rtl/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl (
    input  logic                           adc_sampleclk,
    input  logic                           reset,
    input  logic                           arm_i,
    input  logic                           adc_capture_go_i,
    input  logic                           adc_write_mask_i,
    input  logic                           sample_tick_i,
    input  logic [capture_pkg::COUNT_W-1:0] presample_i,
    input  logic [capture_pkg::COUNT_W-1:0] max_samples_i,
    input  logic                           sample_full_i,
    input  logic                           sample_empty_i,
    output logic                           flush_o,
    output logic                           sample_wr_o,
    output logic                           sample_drain_o,
    output logic                           pack_en_o,
    output logic                           adc_capture_stop_o,
    output logic [capture_pkg::COUNT_W-1:0] samples_o
);

    capture_pkg::cap_state_t           state;
    logic                              arm_r;
    logic                              arm_rise;
    logic                              wr_state;
    logic                              presamp_idle;
    logic [capture_pkg::COUNT_W-1:0]   presamp_cnt;
    logic [capture_pkg::COUNT_W-1:0]   presamp_next;
    logic [capture_pkg::COUNT_W-1:0]   sample_cnt;
    logic [capture_pkg::COUNT_W-1:0]   sample_next;

    assign arm_rise = arm_i && !arm_r;

    assign wr_state = (state == capture_pkg::PRESAMP_FILLING) ||
                      (state == capture_pkg::PRESAMP_FULL) ||
                      (state == capture_pkg::TRIGGERED);

    // with zero presamples there is nothing to drain, so hold off until trigger
    assign presamp_idle = (state == capture_pkg::PRESAMP_FULL) && (presample_i == '0) &&
                          !adc_capture_go_i;

    assign sample_wr_o = wr_state && sample_tick_i && adc_write_mask_i && !sample_full_i &&
                         !presamp_idle;

    // trigger sample is kept, so no drain on that cycle
    assign sample_drain_o = sample_wr_o && (state == capture_pkg::PRESAMP_FULL) &&
                            !adc_capture_go_i;

    // packing only once presamples are committed
    assign pack_en_o = (state == capture_pkg::TRIGGERED) || (state == capture_pkg::DONE);

    assign presamp_next = presamp_cnt + {{(capture_pkg::COUNT_W-1){1'b0}}, sample_wr_o};
    assign sample_next  = sample_cnt + {{(capture_pkg::COUNT_W-1){1'b0}}, sample_wr_o};

    assign samples_o = sample_cnt;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state              <= capture_pkg::IDLE;
            arm_r              <= 1'b0;
            flush_o            <= 1'b0;
            presamp_cnt        <= '0;
            sample_cnt         <= '0;
            adc_capture_stop_o <= 1'b0;
        end else begin
            arm_r   <= arm_i;
            flush_o <= arm_rise;
            if (arm_rise) begin   // re-arm from any state
                state              <= capture_pkg::ARMING;
                presamp_cnt        <= '0;
                sample_cnt         <= '0;
                adc_capture_stop_o <= 1'b0;
            end else begin
                case (state)
                    capture_pkg::ARMING: begin
                        // flush cycle, buffers empty at the next edge
                        state <= (presample_i == '0) ? capture_pkg::PRESAMP_FULL
                                                     : capture_pkg::PRESAMP_FILLING;
                    end
                    capture_pkg::PRESAMP_FILLING: begin
                        presamp_cnt <= presamp_next;
                        if (adc_capture_go_i) begin
                            sample_cnt <= presamp_next;
                            state      <= capture_pkg::TRIGGERED;
                        end else if (presamp_next >= presample_i) begin
                            state <= capture_pkg::PRESAMP_FULL;
                        end
                    end
                    capture_pkg::PRESAMP_FULL: begin
                        if (adc_capture_go_i) begin
                            sample_cnt <= presamp_next;   // presamples plus trigger sample
                            state      <= capture_pkg::TRIGGERED;
                        end
                    end
                    capture_pkg::TRIGGERED: begin
                        sample_cnt <= sample_next;
                        if (sample_next >= max_samples_i) begin
                            adc_capture_stop_o <= 1'b1;
                            state              <= capture_pkg::DONE;
                        end
                    end
                    capture_pkg::DONE: begin
                        if (sample_empty_i)   // packer has taken everything
                            state <= capture_pkg::IDLE;
                    end
                    default: state <= capture_pkg::IDLE;
                endcase
            end
        end
    end

endmodule

// File: rtl/capture_pkg.sv
package capture_pkg;

    // adc sample and packing geometry
    localparam int SAMPLE_W         = 12;
    localparam int SAMPLES_PER_WORD = 3;

    typedef logic [SAMPLE_W-1:0]                  sample_t;
    typedef logic [SAMPLE_W*SAMPLES_PER_WORD-1:0] word_t;   // oldest sample in top bits
    typedef logic [7:0]                           byte_t;

    // counter and control widths
    localparam int COUNT_W      = 16;
    localparam int DOWNSAMPLE_W = 13;

    // buffer depths, powers of two
    localparam int SAMPLE_FIFO_DEPTH = 64;
    localparam int WORD_FIFO_DEPTH   = 256;

    localparam int HIRES_BYTES = 9;   // two words of 12-bit samples

    typedef enum logic [2:0] {
        IDLE            = 3'd0,
        ARMING          = 3'd1,
        PRESAMP_FILLING = 3'd2,
        PRESAMP_FULL    = 3'd3,
        TRIGGERED       = 3'd4,
        DONE            = 3'd5
    } cap_state_t;

endpackage

// File: rtl/capture_top.sv
`timescale 1ns/1ps

module capture_top (
    input  logic                                 adc_sampleclk,
    input  logic                                 reset,
    input  capture_pkg::sample_t                 adc_datain_i,
    input  logic                                 adc_write_mask_i,
    input  logic                                 adc_capture_go_i,
    input  logic                                 arm_i,
    input  logic [capture_pkg::COUNT_W-1:0]      presample_i,
    input  logic [capture_pkg::COUNT_W-1:0]      max_samples_i,
    input  logic [capture_pkg::DOWNSAMPLE_W-1:0] downsample_i,
    input  logic                                 low_res_i,
    input  logic                                 low_res_lsb_i,
    input  logic                                 fifo_read_fifoen_i,
    output logic                                 adc_capture_stop_o,
    output logic [capture_pkg::COUNT_W-1:0]      samples_o,
    output logic                                 fifo_read_fifoempty_o,
    output capture_pkg::byte_t                   fifo_read_data_o
);

    logic                 flush;
    logic                 sample_tick;
    logic                 sample_wr;
    logic                 sample_drain;
    logic                 sample_rd;
    logic                 sample_full;
    logic                 sample_empty;
    capture_pkg::sample_t sample_dout;
    logic                 pack_en;
    logic                 pack_empty;
    logic                 pack_rd;
    logic                 word_wr;
    logic                 word_rd;
    logic                 word_full;
    logic                 word_empty;
    capture_pkg::word_t   word_din;
    capture_pkg::word_t   word_dout;

    assign sample_rd  = sample_drain || pack_rd;     // never both at once
    assign pack_empty = sample_empty || !pack_en;    // presamples stay put until trigger
    assign fifo_read_fifoempty_o = word_empty || word_rd;   // head word stale during pop

    downsampler u_downsampler (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .flush_i (flush),
        .downsample_i (downsample_i), .sample_tick_o (sample_tick)
    );

    capture_ctrl u_capture_ctrl (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .arm_i (arm_i),
        .adc_capture_go_i (adc_capture_go_i), .adc_write_mask_i (adc_write_mask_i),
        .sample_tick_i (sample_tick), .presample_i (presample_i),
        .max_samples_i (max_samples_i), .sample_full_i (sample_full),
        .sample_empty_i (sample_empty), .flush_o (flush), .sample_wr_o (sample_wr),
        .sample_drain_o (sample_drain), .pack_en_o (pack_en),
        .adc_capture_stop_o (adc_capture_stop_o), .samples_o (samples_o)
    );

    sample_fifo #(
        .payload_t (capture_pkg::sample_t), .DEPTH (capture_pkg::SAMPLE_FIFO_DEPTH)
    ) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .flush_i (flush),
        .wr_i (sample_wr), .rd_i (sample_rd), .din_i (adc_datain_i),
        .dout_o (sample_dout), .full_o (sample_full), .empty_o (sample_empty)
    );

    word_packer u_word_packer (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .flush_i (flush),
        .sample_i (sample_dout), .sample_empty_i (pack_empty), .word_full_i (word_full),
        .sample_rd_o (pack_rd), .word_wr_o (word_wr), .word_o (word_din)
    );

    sample_fifo #(
        .payload_t (capture_pkg::word_t), .DEPTH (capture_pkg::WORD_FIFO_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .flush_i (flush),
        .wr_i (word_wr), .rd_i (word_rd), .din_i (word_din),
        .dout_o (word_dout), .full_o (word_full), .empty_o (word_empty)
    );

    byte_unpacker u_byte_unpacker (
        .adc_sampleclk (adc_sampleclk), .reset (reset), .flush_i (flush),
        .word_i (word_dout), .word_empty_i (word_empty), .low_res_i (low_res_i),
        .low_res_lsb_i (low_res_lsb_i), .fifo_read_fifoen_i (fifo_read_fifoen_i),
        .word_rd_o (word_rd), .fifo_read_data_o (fifo_read_data_o)
    );

endmodule

// File: rtl/downsampler.sv
`timescale 1ns/1ps

module downsampler (
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic                                flush_i,
    input  logic [capture_pkg::DOWNSAMPLE_W-1:0] downsample_i,
    output logic                                sample_tick_o
);

    logic [capture_pkg::DOWNSAMPLE_W-1:0] ds_cnt;

    // first tick lands in the cycle right after the flush
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ds_cnt        <= '0;
            sample_tick_o <= 1'b0;
        end else if (flush_i) begin
            ds_cnt        <= '0;
            sample_tick_o <= 1'b1;
        end else if (ds_cnt == downsample_i) begin
            ds_cnt        <= '0;   // wrap, keep this sample
            sample_tick_o <= 1'b1;
        end else begin
            ds_cnt        <= ds_cnt + 1'b1;
            sample_tick_o <= 1'b0;
        end
    end

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps

// first-word-fall-through buffer, DEPTH must be a power of two
module sample_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic     adc_sampleclk,
    input  logic     reset,
    input  logic     flush_i,
    input  logic     wr_i,
    input  logic     rd_i,
    input  payload_t din_i,
    output payload_t dout_o,
    output logic     full_o,
    output logic     empty_o
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       do_wr;
    logic                       do_rd;

    assign full_o  = (count == DEPTH);
    assign empty_o = (count == '0);

    // overflowing writes and underflowing reads are dropped
    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    assign dout_o = mem[rd_ptr];   // head of queue always visible

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= din_i;
    end

endmodule

// File: rtl/word_packer.sv
`timescale 1ns/1ps

module word_packer (
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  capture_pkg::sample_t sample_i,
    input  logic                 sample_empty_i,
    input  logic                 word_full_i,
    output logic                 sample_rd_o,
    output logic                 word_wr_o,
    output capture_pkg::word_t   word_o
);

    logic [1:0]         slot;   // samples already in the word
    capture_pkg::word_t shift_r;

    assign sample_rd_o = !sample_empty_i && !word_full_i;
    assign word_o      = shift_r;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            slot      <= '0;   // partial word dropped
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= sample_rd_o && (slot == capture_pkg::SAMPLES_PER_WORD - 1);
            if (sample_rd_o) begin
                if (slot == capture_pkg::SAMPLES_PER_WORD - 1)
                    slot <= '0;
                else
                    slot <= slot + 2'd1;
            end
        end
    end

    // shift left so the first sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (sample_rd_o)
            shift_r <= {shift_r[$bits(capture_pkg::word_t)-capture_pkg::SAMPLE_W-1:0],
                        sample_i};
    end

endmodule
